//--- source/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Pin and block counts
`define PERIPH_NUM_PINS 16
`define PERIPH_PWM_NUM 2

// Bus window of the unit
`define PERIPH_BASE_ADDR 32'h1000_0000

// PWM phase and setpoint width
`define PERIPH_PWM_WIDTH 8

// PWM prescaler divide value width
`define PERIPH_PWM_DIV_WIDTH 8

`endif

//--- source/periph_pkg.sv
`include "periph_config.svh"

package periph_pkg;

   //////////////////////////////////////////////////////////////////////
   // Bus types
   //////////////////////////////////////////////////////////////////////

   typedef logic [31:0] bus_word_t;

   typedef logic [`PERIPH_NUM_PINS-1:0] pins_t;

   typedef struct packed {
      logic        we;
      logic [31:0] addr;
      bus_word_t   wdata;
      logic [3:0]  be;
   } bus_req_t;

   //////////////////////////////////////////////////////////////////////
   // Configuration from the register file
   //////////////////////////////////////////////////////////////////////

   // Sel bit set hands the pin to its PWM
   typedef struct packed {
      pins_t out;
      pins_t oe;
      pins_t sel;
   } gpio_cfg_t;

   typedef struct packed {
      logic                             en;
      logic [`PERIPH_PWM_DIV_WIDTH-1:0] div;
      logic [`PERIPH_PWM_WIDTH-1:0]     setpoint;
   } pwm_cfg_t;

   // Clr is a one-cycle strobe
   typedef struct packed {
      logic        en;
      logic        clr;
      logic [63:0] cmp;
   } tim_cfg_t;

endpackage

//--- source/periph_reg_file.sv
`include "periph_config.svh"

module periph_reg_file (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_req,
   output logic                  o_gnt,
   input  periph_pkg::bus_req_t  i_bus,
   output logic                  o_rvalid,
   output periph_pkg::bus_word_t o_rdata,
   input  periph_pkg::pins_t     i_gpio_in,
   input  logic [63:0]           i_tim_count,
   output periph_pkg::gpio_cfg_t o_gpio_cfg,
   output periph_pkg::pwm_cfg_t  o_pwm_cfg [`PERIPH_PWM_NUM],
   output periph_pkg::tim_cfg_t  o_tim_cfg
);

   localparam logic [31:0] BASE_ADDR = `PERIPH_BASE_ADDR;
   localparam int          NP        = `PERIPH_NUM_PINS;
   localparam int          DIV_W     = `PERIPH_PWM_DIV_WIDTH;
   localparam int          SP_W      = `PERIPH_PWM_WIDTH;

   localparam logic [7:0] REG_GPIO_OUT  = 8'h00;
   localparam logic [7:0] REG_GPIO_OE   = 8'h04;
   localparam logic [7:0] REG_GPIO_SEL  = 8'h08;
   localparam logic [7:0] REG_GPIO_IN   = 8'h0C;
   localparam logic [7:0] REG_TIM_CTRL  = 8'h10;
   localparam logic [7:0] REG_TIM_CMP_L = 8'h14;
   localparam logic [7:0] REG_TIM_CMP_H = 8'h18;
   localparam logic [7:0] REG_TIM_CNT_L = 8'h1C;
   localparam logic [7:0] REG_TIM_CNT_H = 8'h20;
   localparam logic [7:0] REG_PWM_BASE  = 8'h40;
   localparam logic [7:0] PWM_STRIDE    = 8'h10;
   localparam logic [7:0] REG_PWM_EN    = 8'h00;
   localparam logic [7:0] REG_PWM_DIV   = 8'h04;
   localparam logic [7:0] REG_PWM_SP    = 8'h08;

   logic                  hit;
   logic                  wr_en;
   logic [7:0]            off;
   periph_pkg::bus_word_t rd_word;
   periph_pkg::bus_word_t wr_word;

   function automatic logic [7:0] pwm_off(input int n, input logic [7:0] sub);
      return REG_PWM_BASE + 8'(n) * PWM_STRIDE + sub;
   endfunction

   // Lanes with a clear enable keep the current register value
   function automatic periph_pkg::bus_word_t merge_be(
      input periph_pkg::bus_word_t old_word,
      input periph_pkg::bus_word_t new_word,
      input logic [3:0]            be
   );
      periph_pkg::bus_word_t merged;
      merged = old_word;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            merged[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return merged;
   endfunction

   assign o_gnt = i_req;
   assign hit   = (i_bus.addr[31:8] == BASE_ADDR[31:8]);
   assign off   = i_bus.addr[7:0];
   assign wr_en = i_req & i_bus.we & hit;

   ///////////////////////////////////////////////////////////////////////
   // Read mux, also the old value for byte merges
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      rd_word = '0;
      case (off)
         REG_GPIO_OUT:  rd_word[NP-1:0] = o_gpio_cfg.out;
         REG_GPIO_OE:   rd_word[NP-1:0] = o_gpio_cfg.oe;
         REG_GPIO_SEL:  rd_word[NP-1:0] = o_gpio_cfg.sel;
         REG_GPIO_IN:   rd_word[NP-1:0] = i_gpio_in;
         REG_TIM_CTRL:  rd_word[0] = o_tim_cfg.en;
         REG_TIM_CMP_L: rd_word = o_tim_cfg.cmp[31:0];
         REG_TIM_CMP_H: rd_word = o_tim_cfg.cmp[63:32];
         REG_TIM_CNT_L: rd_word = i_tim_count[31:0];
         REG_TIM_CNT_H: rd_word = i_tim_count[63:32];
         default:       rd_word = '0;
      endcase
      for (int n = 0; n < `PERIPH_PWM_NUM; n++) begin
         if (off == pwm_off(n, REG_PWM_EN)) rd_word[0] = o_pwm_cfg[n].en;
         if (off == pwm_off(n, REG_PWM_DIV)) rd_word[DIV_W-1:0] = o_pwm_cfg[n].div;
         if (off == pwm_off(n, REG_PWM_SP)) rd_word[SP_W-1:0] = o_pwm_cfg[n].setpoint;
      end
      if (!hit) begin
         rd_word = '0;
      end
   end

   assign wr_word = merge_be(rd_word, i_bus.wdata, i_bus.be);

   ///////////////////////////////////////////////////////////////////////
   // Register writes
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gpio_cfg    <= '0;
         o_tim_cfg.en  <= 1'b0;
         o_tim_cfg.clr <= 1'b0;
         o_tim_cfg.cmp <= '1;
         for (int n = 0; n < `PERIPH_PWM_NUM; n++) begin
            o_pwm_cfg[n] <= '0;
         end
      end else begin
         o_tim_cfg.clr <= 1'b0;
         if (wr_en) begin
            case (off)
               REG_GPIO_OUT:  o_gpio_cfg.out <= wr_word[NP-1:0];
               REG_GPIO_OE:   o_gpio_cfg.oe <= wr_word[NP-1:0];
               REG_GPIO_SEL:  o_gpio_cfg.sel <= wr_word[NP-1:0];
               REG_TIM_CTRL: begin
                  o_tim_cfg.en  <= wr_word[0];
                  o_tim_cfg.clr <= wr_word[1];
               end
               REG_TIM_CMP_L: o_tim_cfg.cmp[31:0] <= wr_word;
               REG_TIM_CMP_H: o_tim_cfg.cmp[63:32] <= wr_word;
               default: ;
            endcase
            for (int n = 0; n < `PERIPH_PWM_NUM; n++) begin
               if (off == pwm_off(n, REG_PWM_EN)) o_pwm_cfg[n].en <= wr_word[0];
               if (off == pwm_off(n, REG_PWM_DIV)) o_pwm_cfg[n].div <= wr_word[DIV_W-1:0];
               if (off == pwm_off(n, REG_PWM_SP)) o_pwm_cfg[n].setpoint <= wr_word[SP_W-1:0];
            end
         end
      end
   end

   // Response one cycle after the grant
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rvalid <= 1'b0;
      end else begin
         o_rvalid <= i_req;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_req && !i_bus.we) begin
         o_rdata <= rd_word;
      end
   end

   a_rvalid_after_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_rvalid == $past(i_req));

endmodule

//--- source/pwm_modulator.sv
`include "periph_config.svh"

module pwm_modulator (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  periph_pkg::pwm_cfg_t i_cfg,
   output logic                 o_pwm
);

   logic [`PERIPH_PWM_DIV_WIDTH-1:0] prescale;
   logic [`PERIPH_PWM_WIDTH-1:0]     phase;

   // Phase advances once per prescaler wrap, DIV+1 cycles per step
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         prescale <= '0;
         phase    <= '0;
      end else if (!i_cfg.en) begin
         prescale <= '0;
         phase    <= '0;
      end else if (prescale >= i_cfg.div) begin
         prescale <= '0;
         phase    <= phase + 1'b1;
      end else begin
         prescale <= prescale + 1'b1;
      end
   end

   // High for setpoint phase steps out of 256
   assign o_pwm = i_cfg.en & (phase < i_cfg.setpoint);

   a_low_when_off: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !i_cfg.en |-> !o_pwm);

endmodule

//--- source/machine_timer.sv
module machine_timer (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  periph_pkg::tim_cfg_t i_cfg,
   output logic [63:0]          o_count,
   output logic                 o_irq
);

   // Clear wins over the increment
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_count <= '0;
      end else if (i_cfg.clr) begin
         o_count <= '0;
      end else if (i_cfg.en) begin
         o_count <= o_count + 64'd1;
      end
   end

   // Level interrupt held until the compare moves or the timer stops
   assign o_irq = i_cfg.en & (o_count >= i_cfg.cmp);

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////

   a_no_irq_when_off: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !i_cfg.en |-> !o_irq);

endmodule

//--- source/pin_mux.sv
`include "periph_config.svh"

module pin_mux (
   input  logic                      i_clk,
   input  logic                      i_arst_n,
   input  periph_pkg::gpio_cfg_t     i_cfg,
   input  logic [`PERIPH_PWM_NUM-1:0] i_pwm,
   input  periph_pkg::pins_t         i_io_in,
   output periph_pkg::pins_t         o_gpio_in,
   output periph_pkg::pins_t         o_io_out,
   output periph_pkg::pins_t         o_io_oe
);

   periph_pkg::pins_t sync_q1;

   ///////////////////////////////////////////////////////////////////////
   // Output select per pin
   ///////////////////////////////////////////////////////////////////////

   // PWM functions repeat across the pins
   always_comb begin
      for (int p = 0; p < `PERIPH_NUM_PINS; p++) begin
         if (i_cfg.sel[p]) begin
            o_io_out[p] = i_pwm[p % `PERIPH_PWM_NUM];
            o_io_oe[p]  = 1'b1;
         end else begin
            o_io_out[p] = i_cfg.out[p];
            o_io_oe[p]  = i_cfg.oe[p];
         end
      end
   end

   // Two-flop synchronizer on the pad inputs
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync_q1   <= '0;
         o_gpio_in <= '0;
      end else begin
         sync_q1   <= i_io_in;
         o_gpio_in <= sync_q1;
      end
   end

   a_sel_drives: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (o_io_oe & i_cfg.sel) == i_cfg.sel);

endmodule

//--- source/peripheral_unit.sv
`include "periph_config.svh"

module peripheral_unit (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_req,
   output logic                  o_gnt,
   input  periph_pkg::bus_req_t  i_bus,
   output logic                  o_rvalid,
   output periph_pkg::bus_word_t o_rdata,
   output logic                  o_timer_irq,
   input  periph_pkg::pins_t     i_io_in,
   output periph_pkg::pins_t     o_io_out,
   output periph_pkg::pins_t     o_io_oe
);

   periph_pkg::gpio_cfg_t       gpio_cfg;
   periph_pkg::pwm_cfg_t        pwm_cfg [`PERIPH_PWM_NUM];
   periph_pkg::tim_cfg_t        tim_cfg;
   periph_pkg::pins_t           gpio_in;
   logic [63:0]                 tim_count;
   logic [`PERIPH_PWM_NUM-1:0]  pwm_out;

   periph_reg_file periph_reg_file_inst (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_req       (i_req),
      .o_gnt       (o_gnt),
      .i_bus       (i_bus),
      .o_rvalid    (o_rvalid),
      .o_rdata     (o_rdata),
      .i_gpio_in   (gpio_in),
      .i_tim_count (tim_count),
      .o_gpio_cfg  (gpio_cfg),
      .o_pwm_cfg   (pwm_cfg),
      .o_tim_cfg   (tim_cfg)
   );

   // One modulator per PWM channel
   for (genvar g = 0; g < `PERIPH_PWM_NUM; g++) begin : gen_pwm
      pwm_modulator pwm_modulator_inst (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_cfg    (pwm_cfg[g]),
         .o_pwm    (pwm_out[g])
      );
   end

   machine_timer machine_timer_inst (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_cfg    (tim_cfg),
      .o_count  (tim_count),
      .o_irq    (o_timer_irq)
   );

   pin_mux pin_mux_inst (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .i_cfg     (gpio_cfg),
      .i_pwm     (pwm_out),
      .i_io_in   (i_io_in),
      .o_gpio_in (gpio_in),
      .o_io_out  (o_io_out),
      .o_io_oe   (o_io_oe)
   );

endmodule

//--- bench/tb_peripheral_unit.sv
`include "periph_config.svh"

module tb_peripheral_unit;

   localparam int          CLK_PERIOD   = 20;
   localparam logic [31:0] BASE_ADDR    = `PERIPH_BASE_ADDR;
   localparam int          NP           = `PERIPH_NUM_PINS;
   // Sum of the per-test cycle budgets
   localparam int          TOTAL_CYCLES = 40 + 60 + 120 + 100 + 2200;

   localparam logic [7:0] REG_GPIO_OUT  = 8'h00;
   localparam logic [7:0] REG_GPIO_OE   = 8'h04;
   localparam logic [7:0] REG_GPIO_SEL  = 8'h08;
   localparam logic [7:0] REG_GPIO_IN   = 8'h0C;
   localparam logic [7:0] REG_TIM_CTRL  = 8'h10;
   localparam logic [7:0] REG_TIM_CMP_L = 8'h14;
   localparam logic [7:0] REG_TIM_CMP_H = 8'h18;
   localparam logic [7:0] REG_TIM_CNT_L = 8'h1C;
   localparam logic [7:0] REG_PWM_BASE  = 8'h40;
   localparam logic [7:0] BE_TARGETS [6] = '{8'h14, 8'h18, 8'h44, 8'h48, 8'h54, 8'h58};
   localparam logic [7:0] UNMAPPED [6]   = '{8'h24, 8'h3C, 8'h4C, 8'h60, 8'h80, 8'hFC};

   logic                  i_clk;
   logic                  i_arst_n;
   logic                  i_req;
   logic                  o_gnt;
   periph_pkg::bus_req_t  i_bus;
   logic                  o_rvalid;
   periph_pkg::bus_word_t o_rdata;
   logic                  o_timer_irq;
   periph_pkg::pins_t     i_io_in;
   periph_pkg::pins_t     o_io_out;
   periph_pkg::pins_t     o_io_oe;

   logic [31:0]           lfsr = 32'h5f23;
   periph_pkg::bus_word_t model_regs [256];
   periph_pkg::pins_t     pin_drive;
   periph_pkg::bus_word_t pend_exp;
   periph_pkg::bus_word_t last_rdata;
   logic                  pend_valid;
   logic                  pend_read;
   logic                  pend_chk;
   int                    errors;
   int                    checks;
   int                    tests_run;
   int                    tests_failed;

   peripheral_unit peripheral_unit_inst (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_req       (i_req),
      .o_gnt       (o_gnt),
      .i_bus       (i_bus),
      .o_rvalid    (o_rvalid),
      .o_rdata     (o_rdata),
      .o_timer_irq (o_timer_irq),
      .i_io_in     (i_io_in),
      .o_io_out    (o_io_out),
      .o_io_oe     (o_io_oe)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   //////////////////////////////////////////////////////////////////////
   // Random source and register model
   //////////////////////////////////////////////////////////////////////

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [7:0] pwm_off(input int n, input logic [7:0] sub);
      return REG_PWM_BASE + 8'(n * 16) + sub;
   endfunction

   // Bits that exist in each writable register
   function automatic periph_pkg::bus_word_t field_mask(input logic [7:0] off);
      if (off == REG_GPIO_OUT || off == REG_GPIO_OE || off == REG_GPIO_SEL) begin
         return 32'((64'd1 << NP) - 1);
      end
      if (off == REG_TIM_CTRL) return 32'h1;
      if (off == REG_TIM_CMP_L || off == REG_TIM_CMP_H) return 32'hFFFF_FFFF;
      for (int n = 0; n < `PERIPH_PWM_NUM; n++) begin
         if (off == pwm_off(n, 8'h00)) return 32'h1;
         if (off == pwm_off(n, 8'h04) || off == pwm_off(n, 8'h08)) return 32'hFF;
      end
      return '0;
   endfunction

   function automatic void model_write(input logic [7:0] off,
                                       input periph_pkg::bus_word_t data,
                                       input logic [3:0] be);
      periph_pkg::bus_word_t lanes;
      lanes = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      model_regs[off] = ((model_regs[off] & ~lanes) | (data & lanes)) & field_mask(off);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input periph_pkg::bus_word_t got,
                             input periph_pkg::bus_word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pins(input string name, input periph_pkg::pins_t got,
                             input periph_pkg::pins_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus driver, one call per clock cycle
   //////////////////////////////////////////////////////////////////////

   // Drives on the rising edge, checks the previous response at the falling edge
   task automatic bus_cycle(input logic req, input logic we, input logic [7:0] off,
                            input periph_pkg::bus_word_t wdata, input logic [3:0] be,
                            input logic chk, input periph_pkg::bus_word_t exp);
      @(posedge i_clk);
      i_req   <= req;
      i_bus   <= '{we, BASE_ADDR + 32'(off), wdata, be};
      i_io_in <= pin_drive;
      @(negedge i_clk);
      check_bit("o_gnt", o_gnt, req);
      check_bit("o_rvalid", o_rvalid, pend_valid);
      if (pend_valid && pend_read) begin
         last_rdata = o_rdata;
         if (pend_chk) begin
            check_word("o_rdata", o_rdata, pend_exp);
         end
      end
      pend_valid = req;
      pend_read  = req & ~we;
      pend_chk   = chk;
      pend_exp   = exp;
   endtask

   task automatic write_reg(input logic [7:0] off, input periph_pkg::bus_word_t data,
                            input logic [3:0] be);
      model_write(off, data, be);
      bus_cycle(1'b1, 1'b1, off, data, be, 1'b0, '0);
   endtask

   task automatic read_reg(input logic [7:0] off, input periph_pkg::bus_word_t exp);
      bus_cycle(1'b1, 1'b0, off, '0, 4'h0, 1'b1, exp);
   endtask

   task automatic read_any(input logic [7:0] off);
      bus_cycle(1'b1, 1'b0, off, '0, 4'h0, 1'b0, '0);
   endtask

   task automatic idle_cycle();
      bus_cycle(1'b0, 1'b0, 8'h00, '0, 4'h0, 1'b0, '0);
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errs_before);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_gpio_out();
      for (int i = 0; i < 8; i++) begin
         write_reg(REG_GPIO_OUT, rand_bits(32), 4'hF);
         write_reg(REG_GPIO_OE, rand_bits(32), 4'hF);
         idle_cycle();
         check_pins("o_io_out", o_io_out, model_regs[REG_GPIO_OUT][NP-1:0]);
         check_pins("o_io_oe", o_io_oe, model_regs[REG_GPIO_OE][NP-1:0]);
      end
   endtask

   task automatic test_gpio_in();
      for (int i = 0; i < 8; i++) begin
         pin_drive = rand_bits(NP);
         repeat (3) idle_cycle();
         read_reg(REG_GPIO_IN, 32'(pin_drive));
         idle_cycle();
      end
   endtask

   task automatic test_byte_writes();
      logic [7:0] off;
      for (int i = 0; i < 24; i++) begin
         off = BE_TARGETS[rand_bits(8) % 6];
         write_reg(off, rand_bits(32), rand_bits(4));
         read_reg(off, model_regs[off]);
      end
      for (int i = 0; i < 6; i++) begin
         read_reg(UNMAPPED[i], '0);
      end
      idle_cycle();
   endtask

   task automatic test_timer_irq();
      int n_cmp;
      n_cmp = int'(rand_bits(6));
      if (n_cmp == 0) n_cmp = 1;
      write_reg(REG_TIM_CTRL, 32'h2, 4'hF);
      write_reg(REG_TIM_CMP_H, '0, 4'hF);
      write_reg(REG_TIM_CMP_L, 32'(n_cmp), 4'hF);
      write_reg(REG_TIM_CTRL, 32'h1, 4'hF);
      // First idle edge is the enable write edge
      for (int k = 0; k <= n_cmp + 1; k++) begin
         idle_cycle();
         check_bit("o_timer_irq", o_timer_irq, k >= n_cmp);
      end
      read_any(REG_TIM_CNT_L);
      idle_cycle();
      checks++;
      if (last_rdata < 32'(n_cmp)) begin
         errors++;
         $display("timer count %0d read back below its compare value %0d", last_rdata, n_cmp);
      end
      write_reg(REG_TIM_CTRL, '0, 4'hF);
      idle_cycle();
      check_bit("o_timer_irq", o_timer_irq, 1'b0);
   endtask

   task automatic test_pwm();
      int n;
      int div;
      int sp;
      int high;
      for (int i = 0; i < 2; i++) begin
         n   = int'(rand_bits(1));
         div = int'(rand_bits(2));
         sp  = int'(rand_bits(8));
         high = 0;
         write_reg(pwm_off(n, 8'h04), 32'(div), 4'hF);
         write_reg(pwm_off(n, 8'h08), 32'(sp), 4'hF);
         write_reg(REG_GPIO_SEL, 32'h5555 << n, 4'hF);
         write_reg(pwm_off(n, 8'h00), 32'h1, 4'hF);
         idle_cycle();
         repeat (256 * (div + 1)) begin
            idle_cycle();
            if (o_io_out[n]) high++;
            check_bit("o_io_oe", o_io_oe[n], 1'b1);
         end
         check_word("pwm high cycles", 32'(high), 32'(sp * (div + 1)));
         write_reg(pwm_off(n, 8'h00), '0, 4'hF);
         idle_cycle();
         check_bit("o_io_out", o_io_out[n], 1'b0);
         write_reg(REG_GPIO_SEL, '0, 4'hF);
         idle_cycle();
      end
   endtask

   initial begin
      int errs;
      i_clk      = 1'b0;
      i_arst_n   = 1'b0;
      i_req      = 1'b0;
      i_bus      = '0;
      i_io_in    = '0;
      pin_drive  = '0;
      pend_valid = 1'b0;
      pend_read  = 1'b0;
      pend_chk   = 1'b0;
      pend_exp   = '0;
      last_rdata = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < 256; i++) begin
         model_regs[i] = '0;
      end
      // Compare resets to all ones
      model_regs[REG_TIM_CMP_L] = '1;
      model_regs[REG_TIM_CMP_H] = '1;
      repeat (5) @(posedge i_clk);
      i_arst_n <= 1'b1;

      errs = errors;
      test_gpio_out();
      end_test("gpio_out", errs);
      errs = errors;
      test_gpio_in();
      end_test("gpio_in", errs);
      errs = errors;
      test_byte_writes();
      end_test("byte_writes", errs);
      errs = errors;
      test_timer_irq();
      end_test("timer_irq", errs);
      errs = errors;
      test_pwm();
      end_test("pwm", errs);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(2 * TOTAL_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("sim failed");
      $finish;
   end

endmodule

//--- all.f
+incdir+source
source/periph_pkg.sv
source/periph_reg_file.sv
source/pwm_modulator.sv
source/machine_timer.sv
source/pin_mux.sv
source/peripheral_unit.sv
bench/tb_peripheral_unit.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_peripheral_unit
FILELIST   = all.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: build run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run:
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
